// ==== hw/trace_pkg.sv ====
// shared types and constants for the parallel trace port front end
// every RTL block takes these by wildcard import in its module header

`default_nettype none

package trace_pkg;

   ///////////////////////////////////////////////////////////////////////
   // trace window
   ///////////////////////////////////////////////////////////////////////

   // depth of the shift window in bits
   localparam int window_bits = 64;

   // window in trace bit order with the first-received bit at bit 0
   typedef logic [window_bits-1:0] trace_window_t;

   // sync frame signature used to find byte alignment
   // top of the window must hold a full 7fff sync
   localparam logic [15:0] sync_head = 16'h7fff;
   // low byte must be an ff sync byte
   localparam logic [7:0]  sync_tail = 8'hff;

   ///////////////////////////////////////////////////////////////////////
   // match rules
   ///////////////////////////////////////////////////////////////////////

   // one compare rule where only bits set in mask take part
   typedef struct packed {
      trace_window_t pattern;
      trace_window_t mask;
   } match_rule_t;

   // per-rule hit count that wraps
   typedef logic [7:0] count_t;

   ///////////////////////////////////////////////////////////////////////
   // port control and lock state
   ///////////////////////////////////////////////////////////////////////

   // active pin count on the trace port
   // any other code freezes the window
   typedef enum logic [2:0] {
      width_1 = 3'd1,
      width_2 = 3'd2,
      width_4 = 3'd4
   } port_width_t;

   // sync tracker states
   typedef enum logic {
      hunting = 1'b0,
      locked  = 1'b1
   } sync_state_t;

endpackage

`default_nettype wire

// ==== hw/trace_shift_buffer.sv ====
// trace pin shift register
// shifts 1, 2 or 4 pins per trace_clk and presents the window in trace bit order
// newest pins land at the top of the window, pin 0 highest

`timescale 1ns/10ps
`default_nettype none

module trace_shift_buffer
   import trace_pkg::*;
(
   input  logic          trace_clk,
   input  logic          reset,
   input  logic [3:0]    trace_data,
   input  port_width_t   port_width,
   output trace_window_t window
);

   // raw shift register, newest pins at the low end
   trace_window_t shift_q;

   ///////////////////////////////////////////////////////////////////////
   // shift in
   ///////////////////////////////////////////////////////////////////////

   // pins enter at bit 0 with pin 0 lowest,
   // so the reversal below puts pin 0 at the window top
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         shift_q <= '0;
      end else begin
         case (port_width)
            width_4: begin
               shift_q <= {shift_q[window_bits-5:0], trace_data[3:0]};
            end
            width_2: begin
               shift_q <= {shift_q[window_bits-3:0], trace_data[1:0]};
            end
            width_1: begin
               shift_q <= {shift_q[window_bits-2:0], trace_data[0]};
            end
            default: begin
               // unsupported width holds the window
               shift_q <= shift_q;
            end
         endcase
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // bit order fix
   ///////////////////////////////////////////////////////////////////////

   // oldest bit ends up at bit 0
   // matches how the trace protocol lays out bytes
   always_comb begin
      for (int b = 0; b < window_bits; b++) begin
         window[b] = shift_q[window_bits-1-b];
      end
   end

endmodule

`default_nettype wire

// ==== hw/sync_tracker.sv ====
// sync frame tracker for the parallel trace port
// hunts for a sync frame in the window, then holds lock until a manual
// resync or a change of port width

`timescale 1ns/10ps
`default_nettype none

module sync_tracker
   import trace_pkg::*;
(
   input  logic          trace_clk,
   input  logic          reset,
   input  trace_window_t window,
   input  port_width_t   port_width,
   input  logic          resync,
   output logic          locked,
   output logic          lock_start
);

   localparam int head_bits = $bits(sync_head);
   localparam int tail_bits = $bits(sync_tail);

   sync_state_t state;
   // width seen at the previous edge
   port_width_t width_q;
   logic        frame_seen;
   logic        drop_lock;

   ///////////////////////////////////////////////////////////////////////
   // lock conditions
   ///////////////////////////////////////////////////////////////////////

   // sync at both ends of the window
   // catches full and half sync frames
   assign frame_seen = (window[window_bits-1 -: head_bits] == sync_head) &&
                       (window[tail_bits-1:0] == sync_tail);

   // manual resync or a width change both force a new hunt
   assign drop_lock = resync || (port_width != width_q);

   // dropping wins over a fresh frame in the same cycle
   assign lock_start = (state == hunting) && frame_seen && !drop_lock;

   // lock level straight from the state
   assign locked = (state == trace_pkg::locked);

   ///////////////////////////////////////////////////////////////////////
   // state machine
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state   <= hunting;
         width_q <= port_width_t'(3'd0);
      end else begin
         width_q <= port_width;
         if (drop_lock) begin
            state <= hunting;
         end else if (lock_start) begin
            state <= trace_pkg::locked;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/beat_counter.sv ====
// byte alignment counter
// counts trace_clk beats since lock and flags the cycles where the
// window has just completed a new byte for the current port width

`timescale 1ns/10ps
`default_nettype none

module beat_counter
   import trace_pkg::*;
(
   input  logic        trace_clk,
   input  logic        reset,
   input  logic        locked,
   input  logic        lock_start,
   input  port_width_t port_width,
   output logic        byte_strobe
);

   // 8 beats cover one byte at width 1
   typedef logic [2:0] beat_t;

   beat_t beat_q;
   logic  aligned;

   ///////////////////////////////////////////////////////////////////////
   // beat count
   ///////////////////////////////////////////////////////////////////////

   // lock edge already has one aligned byte behind it, so start at 1
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         beat_q <= '0;
      end else if (lock_start) begin
         beat_q <= beat_t'(1);
      end else if (locked) begin
         // wraps on purpose
         beat_q <= beat_q + beat_t'(1);
      end else begin
         beat_q <= '0;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // byte cadence
   ///////////////////////////////////////////////////////////////////////

   // every 8, 4 or 2 beats for 1, 2 or 4 pins
   always_comb begin
      case (port_width)
         width_1: aligned = (beat_q == 3'd0);
         width_2: aligned = (beat_q[1:0] == 2'd0);
         width_4: aligned = (beat_q[0] == 1'b0);
         default: aligned = 1'b0;
      endcase
   end

   assign byte_strobe = locked && aligned;

endmodule

`default_nettype wire

// ==== hw/pattern_matcher.sv ====
// masked pattern compare on byte-aligned trace windows
// registers per-rule hits, keeps the last matched window and rule set,
// and raises the armed trigger on rising edges of hits or ext_trig

`timescale 1ns/10ps
`default_nettype none

module pattern_matcher
   import trace_pkg::*;
#(
   parameter int match_rules = 8
) (
   input  logic                   trace_clk,
   input  logic                   reset,
   input  trace_window_t          window,
   input  logic                   byte_strobe,
   input  match_rule_t            rules [match_rules],
   input  logic [match_rules-1:0] pattern_enable,
   input  logic [match_rules-1:0] trig_enable,
   input  logic                   capturing,
   input  logic                   arm,
   input  logic                   ext_trig,
   input  logic                   soft_trig_enable,
   output logic [match_rules-1:0] match_bits,
   output trace_window_t          matched_data,
   output logic [match_rules-1:0] matched_rules,
   output logic                   trigger
);

   logic [match_rules-1:0] hit;
   logic                   capturing_q;
   logic                   ext_trig_q;
   logic                   trig_hit_rise;
   logic                   ext_trig_rise;

   ///////////////////////////////////////////////////////////////////////
   // rule compare
   ///////////////////////////////////////////////////////////////////////

   // only on byte strobes
   // trigger-enabled rules may hit outside capture so they can start one
   always_comb begin
      for (int r = 0; r < match_rules; r++) begin
         hit[r] = ((window & rules[r].mask) == (rules[r].pattern & rules[r].mask)) &&
                  pattern_enable[r] &&
                  byte_strobe &&
                  (capturing_q || trig_enable[r]);
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // trigger edges
   ///////////////////////////////////////////////////////////////////////

   // match_bits holds last cycle's hits, so this is a rising edge
   assign trig_hit_rise = (|(hit & trig_enable)) && !(|(match_bits & trig_enable));

   // external trigger only counts when soft triggering is on
   assign ext_trig_rise = ext_trig && !ext_trig_q && soft_trig_enable;

   ///////////////////////////////////////////////////////////////////////
   // registers
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         capturing_q   <= 1'b0;
         ext_trig_q    <= 1'b0;
         match_bits    <= '0;
         matched_data  <= '0;
         matched_rules <= '0;
         trigger       <= 1'b0;
      end else begin
         capturing_q <= capturing;
         ext_trig_q  <= ext_trig;
         match_bits  <= hit;
         // snapshot of the window that produced the hit
         if (|hit) begin
            matched_data  <= window;
            matched_rules <= hit;
         end
         // single-cycle pulse gated by arm
         trigger <= arm && (ext_trig_rise || trig_hit_rise);
      end
   end

endmodule

`default_nettype wire

// ==== hw/match_counters.sv ====
// per-rule hit counters
// one 8-bit wrapping counter per rule, bumped on each cycle its hit bit is set

`timescale 1ns/10ps
`default_nettype none

module match_counters
   import trace_pkg::*;
#(
   parameter int match_rules = 8
) (
   input  logic                   trace_clk,
   input  logic                   reset,
   input  logic [match_rules-1:0] match_bits,
   output count_t                 trace_counts [match_rules]
);

   ///////////////////////////////////////////////////////////////////////
   // counter bank
   ///////////////////////////////////////////////////////////////////////

   // overflow wraps to zero
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         for (int r = 0; r < match_rules; r++) begin
            trace_counts[r] <= '0;
         end
      end else begin
         for (int r = 0; r < match_rules; r++) begin
            if (match_bits[r]) begin
               trace_counts[r] <= trace_counts[r] + count_t'(1);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/trace_frontend.sv ====
// parallel trace port front end, top level
// shift window, sync lock, byte cadence, pattern match and hit counters,
// all on trace_clk; match_rules sets the number of compare rules

`timescale 1ns/10ps
`default_nettype none

module trace_frontend
   import trace_pkg::*;
#(
   parameter int match_rules = 8
) (
   input  logic                   trace_clk,
   input  logic                   reset,
   // trace port pins and width
   input  logic [3:0]             trace_data,
   input  port_width_t            port_width,
   input  logic                   resync,
   // capture and trigger control
   input  logic                   capturing,
   input  logic                   arm,
   input  logic                   ext_trig,
   input  logic                   soft_trig_enable,
   // rule setup
   input  match_rule_t            rules [match_rules],
   input  logic [match_rules-1:0] pattern_enable,
   input  logic [match_rules-1:0] trig_enable,
   // status and results
   output logic                   sync_status,
   output logic [match_rules-1:0] match_bits,
   output trace_window_t          matched_data,
   output logic [match_rules-1:0] matched_rules,
   output logic                   trigger,
   output count_t                 trace_counts [match_rules]
);

   trace_window_t window;
   logic          locked;
   logic          lock_start;
   logic          byte_strobe;

   // lock state is reported as is
   assign sync_status = locked;

   ///////////////////////////////////////////////////////////////////////
   // window and alignment
   ///////////////////////////////////////////////////////////////////////

   trace_shift_buffer u_trace_shift_buffer (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .trace_data (trace_data),
      .port_width (port_width),
      .window     (window)
   );

   sync_tracker u_sync_tracker (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .window     (window),
      .port_width (port_width),
      .resync     (resync),
      .locked     (locked),
      .lock_start (lock_start)
   );

   beat_counter u_beat_counter (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .locked      (locked),
      .lock_start  (lock_start),
      .port_width  (port_width),
      .byte_strobe (byte_strobe)
   );

   ///////////////////////////////////////////////////////////////////////
   // matching and counting
   ///////////////////////////////////////////////////////////////////////

   pattern_matcher #(
      .match_rules (match_rules)
   ) u_pattern_matcher (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .window           (window),
      .byte_strobe      (byte_strobe),
      .rules            (rules),
      .pattern_enable   (pattern_enable),
      .trig_enable      (trig_enable),
      .capturing        (capturing),
      .arm              (arm),
      .ext_trig         (ext_trig),
      .soft_trig_enable (soft_trig_enable),
      .match_bits       (match_bits),
      .matched_data     (matched_data),
      .matched_rules    (matched_rules),
      .trigger          (trigger)
   );

   match_counters #(
      .match_rules (match_rules)
   ) u_match_counters (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .match_bits   (match_bits),
      .trace_counts (trace_counts)
   );

endmodule

`default_nettype wire

// ==== test/trace_model.svh ====
// reference model of the trace front end, included inside the testbench module
// the includer declares n_rules first; one call to advance_reference per edge

`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

trace_window_t      ref_window;
trace_window_t      ref_matched_data;
logic               ref_locked;
logic [2:0]         ref_width_q;
logic [2:0]         ref_beat;
logic               ref_cap_q;
logic               ref_ext_q;
logic               ref_trigger;
logic [n_rules-1:0] ref_match_bits;
logic [n_rules-1:0] ref_matched_rules;
count_t             ref_counts [n_rules];

task automatic clear_reference();
   ref_window = '0;
   ref_matched_data = '0;
   ref_locked = 1'b0;
   ref_width_q = '0;
   ref_beat = '0;
   ref_cap_q = 1'b0;
   ref_ext_q = 1'b0;
   ref_trigger = 1'b0;
   ref_match_bits = '0;
   ref_matched_rules = '0;
   for (int r = 0; r < n_rules; r++) begin
      ref_counts[r] = '0;
   end
endtask

task automatic advance_reference(input logic [3:0] pins, input logic [2:0] width,
      input logic resync_in, input logic capturing_in, input logic arm_in,
      input logic ext_in, input logic soft_in, input match_rule_t rule_set [n_rules],
      input logic [n_rules-1:0] enable_set, input logic [n_rules-1:0] trig_set);
   logic               frame;
   logic               drop;
   logic               start;
   logic               strobe;
   logic [n_rules-1:0] hits;
   int                 step;
   step = (width == 3'd1 || width == 3'd2 || width == 3'd4) ? int'(width) : 0;
   // full sync frame has 7fff on top and ff in the low byte
   frame = (ref_window[63:48] == 16'h7fff) && (ref_window[7:0] == 8'hff);
   drop = resync_in || (width != ref_width_q);
   start = !ref_locked && frame && !drop;
   // one byte every 8 / step beats
   strobe = ref_locked && (step != 0) && ((int'(ref_beat) % (8 / (step > 0 ? step : 1))) == 0);
   for (int r = 0; r < n_rules; r++) begin
      hits[r] = ((ref_window & rule_set[r].mask) == (rule_set[r].pattern & rule_set[r].mask))
                && enable_set[r] && strobe && (ref_cap_q || trig_set[r]);
      // counters follow last cycle's hit bits
      if (ref_match_bits[r]) ref_counts[r] = ref_counts[r] + 8'd1;
   end
   ref_trigger = arm_in && ((ext_in && !ref_ext_q && soft_in) ||
                 ((|(hits & trig_set)) && !(|(ref_match_bits & trig_set))));
   if (|hits) begin
      ref_matched_data  = ref_window;
      ref_matched_rules = hits;
   end
   ref_match_bits = hits;
   ref_cap_q = capturing_in;
   ref_ext_q = ext_in;
   ref_beat = start ? 3'd1 : (ref_locked ? ref_beat + 3'd1 : 3'd0);
   ref_locked = drop ? 1'b0 : (start ? 1'b1 : ref_locked);
   ref_width_q = width;
   // oldest bits drop off the bottom and pin 0 lands on top
   ref_window = ref_window >> step;
   for (int i = 0; i < step; i++) begin
      ref_window[63-i] = pins[i];
   end
endtask

`endif

// ==== test/tb_trace_frontend.sv ====
// testbench for the trace front end
// random pins with sync bursts and idle runs, width changes and trigger
// controls, checked every cycle against the model in trace_model.svh

`timescale 1ns/10ps
`default_nettype none

module tb_trace_frontend
   import trace_pkg::*;
();

   localparam int  n_rules       = 8;
   localparam int  num_cycles    = 6000;
   localparam int  reset_cycles  = 5;
   localparam int  margin_cycles = 200;
   localparam time clk_period    = 100;

   logic               trace_clk = 1'b0;
   logic               reset;
   logic [3:0]         trace_data;
   port_width_t        port_width;
   logic               resync;
   logic               capturing;
   logic               arm;
   logic               ext_trig;
   logic               soft_trig_enable;
   match_rule_t        rules [n_rules];
   logic [n_rules-1:0] pattern_enable;
   logic [n_rules-1:0] trig_enable;
   logic [n_rules-1:0] match_bits;
   logic [n_rules-1:0] matched_rules;
   logic               sync_status;
   logic               trigger;
   trace_window_t      matched_data;
   count_t             trace_counts [n_rules];
   // pending sync frame bits in trace order
   logic               sync_bits [$];
   int                 idle_left;

   `include "trace_model.svh"

   always #(clk_period/2) trace_clk = ~trace_clk;

   trace_frontend #(.match_rules(n_rules)) u_trace_frontend (.*);

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Done: errors found");
         $fatal(1, "output mismatch on %s", name);
      end
   endtask

   task automatic compare_outputs();
      check_value("sync_status", 64'(sync_status), 64'(ref_locked));
      check_value("match_bits", 64'(match_bits), 64'(ref_match_bits));
      check_value("matched_data", matched_data, ref_matched_data);
      check_value("matched_rules", 64'(matched_rules), 64'(ref_matched_rules));
      check_value("trigger", 64'(trigger), 64'(ref_trigger));
      for (int r = 0; r < n_rules; r++) begin
         check_value($sformatf("trace_counts[%0d]", r), 64'(trace_counts[r]),
                     64'(ref_counts[r]));
      end
   endtask

   // rule 0 matches an all-ones idle window and the rest watch 3 bits each
   task automatic randomize_rules();
      match_rule_t rule;
      for (int r = 0; r < n_rules; r++) begin
         rule.pattern = {$urandom, $urandom};
         rule.mask = '0;
         repeat (3) rule.mask[$urandom_range(63, 0)] = 1'b1;
         if (r == 0) rule = '1;
         rules[r] <= rule;
      end
      pattern_enable <= n_rules'($urandom) | n_rules'(1);
      trig_enable <= n_rules'($urandom & $urandom);
   endtask

   task automatic drive_inputs(input int cycle);
      logic [2:0] width;
      logic [3:0] pins;
      int         step;
      width = port_width;
      if ($urandom_range(299, 0) == 0) begin
         // code 3 is unsupported and holds the window
         case ($urandom_range(7, 0))
            0: width = 3'd3;
            1, 2: width = 3'd1;
            3, 4: width = 3'd2;
            default: width = 3'd4;
         endcase
         sync_bits.delete();
      end
      if (sync_bits.size() == 0 && idle_left == 0 && $urandom_range(999, 0) < 20) begin
         // seven ff bytes then 7f in lsb-first order
         for (int i = 0; i < 64; i++) sync_bits.push_back(!(i == 63));
         if ($urandom_range(3, 0) == 0) idle_left = $urandom_range(96, 64);
      end
      step = (width == 3'd1 || width == 3'd2 || width == 3'd4) ? int'(width) : 0;
      pins = 4'($urandom);
      if (step > 0 && sync_bits.size() > 0) begin
         // earliest bit goes to the highest active pin
         for (int j = 0; j < step; j++) pins[step-1-j] = sync_bits.pop_front();
      end else if (idle_left > 0) begin
         pins = 4'hf;
         idle_left--;
      end
      port_width <= port_width_t'(width);
      trace_data <= pins;
      resync <= ($urandom_range(399, 0) == 0);
      ext_trig <= ($urandom_range(7, 0) == 0);
      if ($urandom_range(49, 0) == 0) capturing <= !capturing;
      if ($urandom_range(59, 0) == 0) arm <= !arm;
      if ($urandom_range(99, 0) == 0) soft_trig_enable <= !soft_trig_enable;
      if (cycle % 1000 == 999) randomize_rules();
   endtask

   // outputs settle well before the falling edge
   always @(negedge trace_clk) begin
      if (!reset) compare_outputs();
   end

   initial begin
      void'($urandom(32'hbdec6148));
      reset = 1'b1;
      trace_data = 4'h0;
      port_width = width_1;
      resync = 1'b0;
      capturing = 1'b0;
      arm = 1'b0;
      ext_trig = 1'b0;
      soft_trig_enable = 1'b0;
      idle_left = 0;
      randomize_rules();
      clear_reference();
      repeat (reset_cycles) @(posedge trace_clk);
      reset <= 1'b0;
      for (int cycle = 0; cycle < num_cycles; cycle++) begin
         @(posedge trace_clk);
         advance_reference(trace_data, port_width, resync, capturing, arm, ext_trig,
                           soft_trig_enable, rules, pattern_enable, trig_enable);
         drive_inputs(cycle);
      end
      @(negedge trace_clk);
      @(posedge trace_clk);
      $display("Done: no errors");
      $finish;
   end

   // watchdog
   initial begin
      #((reset_cycles + num_cycles + margin_cycles) * clk_period);
      $display("watchdog: the run did not end within its cycle budget");
      $display("Done: errors found");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// ==== trace_frontend.f ====
+incdir+test
hw/trace_pkg.sv
hw/trace_shift_buffer.sv
hw/sync_tracker.sv
hw/beat_counter.sv
hw/pattern_matcher.sv
hw/match_counters.sv
hw/trace_frontend.sv
test/tb_trace_frontend.sv
